//--- source/panel_pkg.sv
`default_nettype none

package panel_pkg;

    // default panel geometry, the largest the types below can hold
    localparam int DEFAULT_PIXEL_WIDTH = 64;
    localparam int DEFAULT_PIXEL_HALFHEIGHT = 16;
    localparam int DEFAULT_BRIGHTNESS_LEVELS = 8;
    // oe length of the least significant plane, in clk_in cycles
    localparam int DEFAULT_BASE_TICKS = 4;

    // column and row indices
    // a smaller panel only uses the low bits
    typedef logic [$clog2(DEFAULT_PIXEL_WIDTH)-1:0] col_t;
    typedef logic [$clog2(DEFAULT_PIXEL_HALFHEIGHT)-1:0] row_t;

    // one-hot plane select, msb plane shifted first
    typedef logic [DEFAULT_BRIGHTNESS_LEVELS-1:0] plane_mask_t;

    // low 3*BRIGHTNESS_LEVELS bits hold {red, green, blue}, red on top
    typedef logic [3*DEFAULT_BRIGHTNESS_LEVELS-1:0] pixel_t;

    // {red, green, blue} plane bits of one half panel
    typedef logic [2:0] rgb_bits_t;

endpackage

`default_nettype wire

//--- source/wb_pkg.sv
`default_nettype none

package wb_pkg;

    // word address, low bits are {half, row, column}
    // upper bits ignored by the frame store
    typedef logic [15:0] wb_addr_t;

    // data word, pixel sits in the low bits
    typedef logic [31:0] wb_data_t;

endpackage

`default_nettype wire

//--- source/scan_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface scan_rd_if import panel_pkg::*; ();

    // scan position, issued by the scanner
    col_t col;
    row_t row;

    // registered pixel words, one cycle behind col and row
    pixel_t pix_upper;
    pixel_t pix_lower;

    modport scanner (output col, output row);

    modport store (input col, input row, output pix_upper, output pix_lower);

    modport slice (input pix_upper, input pix_lower);

endinterface

`default_nettype wire

//--- source/wb_frame_store.sv
`timescale 1ns/1ps
`default_nettype none

module wb_frame_store import panel_pkg::*, wb_pkg::*; #(
    parameter int PIXEL_WIDTH = DEFAULT_PIXEL_WIDTH,
    parameter int PIXEL_HALFHEIGHT = DEFAULT_PIXEL_HALFHEIGHT,
    parameter int BRIGHTNESS_LEVELS = DEFAULT_BRIGHTNESS_LEVELS
) (
    input  logic     clk_in,
    input  logic     reset,
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  wb_addr_t wb_adr,
    input  wb_data_t wb_dat_w,
    output wb_data_t wb_dat_r,
    output logic     wb_ack,
    scan_rd_if.store rd
);

    localparam int CW = $clog2(PIXEL_WIDTH);
    localparam int RW = $clog2(PIXEL_HALFHEIGHT);
    localparam int AW = CW + RW;
    localparam int DEPTH = PIXEL_WIDTH * PIXEL_HALFHEIGHT;
    // only the colour fields of the active geometry are stored
    localparam pixel_t PIX_MASK = pixel_t'((1 << (3 * BRIGHTNESS_LEVELS)) - 1);

    // one array per half, addressed as {row, column}
    pixel_t mem_upper [DEPTH];
    pixel_t mem_lower [DEPTH];

    logic [AW-1:0] wb_idx;
    logic [AW-1:0] scan_idx;
    logic          wb_half;
    logic          wb_req;

    assign wb_idx = wb_adr[AW-1:0];
    assign wb_half = wb_adr[AW];
    assign scan_idx = {rd.row[RW-1:0], rd.col[CW-1:0]};
    // new request, ack goes out next cycle and never twice in a row
    assign wb_req = wb_cyc && wb_stb && !wb_ack;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    // host port, write lands as ack rises
    always_ff @(posedge clk_in) begin
        if (wb_req && wb_we && !wb_half) begin
            mem_upper[wb_idx] <= pixel_t'(wb_dat_w) & PIX_MASK;
        end
        if (wb_req && wb_we && wb_half) begin
            mem_lower[wb_idx] <= pixel_t'(wb_dat_w) & PIX_MASK;
        end
        if (wb_req) begin
            wb_dat_r <= wb_data_t'(wb_half ? mem_lower[wb_idx] : mem_upper[wb_idx]);
        end
    end

    // scan port, both halves read together
    always_ff @(posedge clk_in) begin
        rd.pix_upper <= mem_upper[scan_idx];
        rd.pix_lower <= mem_lower[scan_idx];
    end

endmodule

`default_nettype wire

//--- source/matrix_scan.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_scan import panel_pkg::*; #(
    parameter int PIXEL_WIDTH = DEFAULT_PIXEL_WIDTH,
    parameter int PIXEL_HALFHEIGHT = DEFAULT_PIXEL_HALFHEIGHT,
    parameter int BRIGHTNESS_LEVELS = DEFAULT_BRIGHTNESS_LEVELS
) (
    input  logic        clk_in,
    input  logic        reset,
    scan_rd_if.scanner  rd,
    input  logic        output_enable,
    input  logic        overlap_ok,
    output logic        shift_phase,
    output logic        latch_req,
    output row_t        row_address,
    output plane_mask_t plane_mask
);

    localparam col_t LAST_COL = col_t'(PIXEL_WIDTH - 1);
    localparam row_t LAST_ROW = row_t'(PIXEL_HALFHEIGHT - 1);
    localparam plane_mask_t TOP_PLANE = plane_mask_t'(1) << (BRIGHTNESS_LEVELS - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT,
        ST_WAIT_OE,
        ST_LATCH
    } scan_state_t;

    scan_state_t state;
    col_t        col;
    row_t        row;

    // column and row go straight to the frame store
    assign rd.col = col;
    assign rd.row = row;
    assign row_address = row;

    // one cycle strobe, plane_mask still shows the plane just shifted
    assign latch_req = (state == ST_LATCH);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= ST_IDLE;
            col <= LAST_COL;
            row <= '0;
            shift_phase <= 1'b0;
            plane_mask <= TOP_PLANE;
        end else begin
            case (state)
                // hold off until the running oe period is near its end
                ST_IDLE: begin
                    if (overlap_ok) begin
                        state <= ST_SHIFT;
                        col <= LAST_COL;
                        shift_phase <= 1'b0;
                    end
                end
                // two cycles per column, data low phase then clock high
                ST_SHIFT: begin
                    shift_phase <= !shift_phase;
                    if (shift_phase) begin
                        if (col == '0) begin
                            state <= ST_WAIT_OE;
                        end else begin
                            col <= col - 1'b1;
                        end
                    end
                end
                // no latch while leds of the previous plane are lit
                ST_WAIT_OE: begin
                    if (!output_enable) begin
                        state <= ST_LATCH;
                    end
                end
                ST_LATCH: begin
                    state <= ST_IDLE;
                    // next plane, msb first
                    // wrap back to the top plane steps the row
                    if (plane_mask[0]) begin
                        plane_mask <= TOP_PLANE;
                        if (row == LAST_ROW) begin
                            row <= '0;
                        end else begin
                            row <= row + 1'b1;
                        end
                    end else begin
                        plane_mask <= plane_mask >> 1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/brightness_timer.sv
`timescale 1ns/1ps
`default_nettype none

module brightness_timer import panel_pkg::*; #(
    parameter int PIXEL_WIDTH = DEFAULT_PIXEL_WIDTH,
    parameter int BRIGHTNESS_LEVELS = DEFAULT_BRIGHTNESS_LEVELS,
    parameter int BASE_TICKS = DEFAULT_BASE_TICKS
) (
    input  logic        clk_in,
    input  logic        reset,
    input  logic        latch_req,
    input  plane_mask_t plane_mask,
    output logic        output_enable,
    output logic        overlap_ok
);

    // wide enough for the msb plane weight
    localparam int CNT_W = $clog2(BASE_TICKS << (BRIGHTNESS_LEVELS - 1)) + 1;
    // cycles from shift start to the latch
    localparam int unsigned SHIFT_TICKS = 2 * PIXEL_WIDTH + 4;

    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] weight;

    // one-hot plane into BASE_TICKS << bit position
    always_comb begin
        weight = '0;
        for (int i = 0; i < BRIGHTNESS_LEVELS; i++) begin
            if (plane_mask[i]) begin
                weight = weight | CNT_W'(BASE_TICKS << i);
            end
        end
    end

    // oe high the cycle after the latch, for exactly weight cycles
    always_ff @(posedge clk_in) begin
        if (reset) begin
            output_enable <= 1'b0;
            count <= '0;
        end else if (latch_req) begin
            output_enable <= 1'b1;
            count <= weight;
        end else if (output_enable) begin
            count <= count - 1'b1;
            if (count == CNT_W'(1)) begin
                output_enable <= 1'b0;
            end
        end
    end

    // next shift may start once the remaining on-time fits a shift
    assign overlap_ok = !output_enable || (32'(count) <= SHIFT_TICKS);

endmodule

`default_nettype wire

//--- source/half_panel_slice.sv
`timescale 1ns/1ps
`default_nettype none

module half_panel_slice import panel_pkg::*; #(
    parameter int BRIGHTNESS_LEVELS = DEFAULT_BRIGHTNESS_LEVELS,
    // 0 upper half, 1 lower half
    parameter int HALF = 0
) (
    input  logic        clk_in,
    input  logic        reset,
    scan_rd_if.slice    pix,
    input  plane_mask_t plane_mask,
    output rgb_bits_t   bits
);

    localparam int BL = BRIGHTNESS_LEVELS;

    pixel_t      word;
    plane_mask_t plane_q;

    assign word = (HALF == 0) ? pix.pix_upper : pix.pix_lower;

    // plane delayed to line up with the memory read
    always_ff @(posedge clk_in) begin
        if (reset) begin
            plane_q <= '0;
        end else begin
            plane_q <= plane_mask;
        end
    end

    // pick the current plane bit out of each colour field
    assign bits[2] = |(word[2*BL +: BL] & plane_q[BL-1:0]);
    assign bits[1] = |(word[BL +: BL] & plane_q[BL-1:0]);
    assign bits[0] = |(word[0 +: BL] & plane_q[BL-1:0]);

endmodule

`default_nettype wire

//--- source/hub75_out.sv
`timescale 1ns/1ps
`default_nettype none

module hub75_out import panel_pkg::*; (
    input  logic      clk_in,
    input  logic      reset,
    input  rgb_bits_t bits_upper,
    input  rgb_bits_t bits_lower,
    input  logic      shift_phase,
    input  logic      latch_req,
    input  logic      oe_in,
    output logic      r1,
    output logic      g1,
    output logic      b1,
    output logic      r2,
    output logic      g2,
    output logic      b2,
    output logic      clk_pixel,
    output logic      row_latch,
    output logic      output_enable,
    input  row_t      row_address_in,
    output row_t      row_address
);

    // first stage of the strobe delay, colour already one cycle late
    logic shift_d;
    logic latch_d;
    logic oe_d;
    row_t row_d;

    always_ff @(posedge clk_in) begin
        row_d <= row_address_in;
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            {r1, g1, b1} <= '0;
            {r2, g2, b2} <= '0;
            shift_d <= 1'b0;
            latch_d <= 1'b0;
            oe_d <= 1'b0;
            clk_pixel <= 1'b0;
            row_latch <= 1'b0;
            output_enable <= 1'b0;
            row_address <= '0;
        end else begin
            {r1, g1, b1} <= bits_upper;
            {r2, g2, b2} <= bits_lower;
            shift_d <= shift_phase;
            latch_d <= latch_req;
            oe_d <= oe_in;
            clk_pixel <= shift_d;
            row_latch <= latch_d;
            output_enable <= oe_d;
            // row pins move with the latch pulse
            if (latch_d) begin
                row_address <= row_d;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/led_matrix_top.sv
`timescale 1ns/1ps
`default_nettype none

module led_matrix_top import panel_pkg::*, wb_pkg::*; #(
    parameter int PIXEL_WIDTH = DEFAULT_PIXEL_WIDTH,
    parameter int PIXEL_HALFHEIGHT = DEFAULT_PIXEL_HALFHEIGHT,
    parameter int BRIGHTNESS_LEVELS = DEFAULT_BRIGHTNESS_LEVELS,
    parameter int BASE_TICKS = DEFAULT_BASE_TICKS
) (
    input  logic     clk_in,
    input  logic     reset,
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  wb_addr_t wb_adr,
    input  wb_data_t wb_dat_w,
    output wb_data_t wb_dat_r,
    output logic     wb_ack,
    output logic     r1,
    output logic     g1,
    output logic     b1,
    output logic     r2,
    output logic     g2,
    output logic     b2,
    output logic     clk_pixel,
    output logic     row_latch,
    output logic     output_enable,
    output row_t     row_address
);

    logic        shift_phase;
    logic        latch_req;
    logic        oe_int;
    logic        overlap_ok;
    row_t        scan_row;
    plane_mask_t plane_mask;
    rgb_bits_t   slice_bits [2];

    scan_rd_if rd_bus ();

    wb_frame_store #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HALFHEIGHT(PIXEL_HALFHEIGHT),
        .BRIGHTNESS_LEVELS(BRIGHTNESS_LEVELS)
    ) i_wb_frame_store (
        .clk_in(clk_in),
        .reset(reset),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack),
        .rd(rd_bus.store)
    );

    matrix_scan #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HALFHEIGHT(PIXEL_HALFHEIGHT),
        .BRIGHTNESS_LEVELS(BRIGHTNESS_LEVELS)
    ) i_matrix_scan (
        .clk_in(clk_in),
        .reset(reset),
        .rd(rd_bus.scanner),
        .output_enable(oe_int),
        .overlap_ok(overlap_ok),
        .shift_phase(shift_phase),
        .latch_req(latch_req),
        .row_address(scan_row),
        .plane_mask(plane_mask)
    );

    brightness_timer #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .BRIGHTNESS_LEVELS(BRIGHTNESS_LEVELS),
        .BASE_TICKS(BASE_TICKS)
    ) i_brightness_timer (
        .clk_in(clk_in),
        .reset(reset),
        .latch_req(latch_req),
        .plane_mask(plane_mask),
        .output_enable(oe_int),
        .overlap_ok(overlap_ok)
    );

    // upper half is slice 0, lower half slice 1
    for (genvar h = 0; h < 2; h++) begin : g_half
        half_panel_slice #(
            .BRIGHTNESS_LEVELS(BRIGHTNESS_LEVELS),
            .HALF(h)
        ) i_half_panel_slice (
            .clk_in(clk_in),
            .reset(reset),
            .pix(rd_bus.slice),
            .plane_mask(plane_mask),
            .bits(slice_bits[h])
        );
    end

    hub75_out i_hub75_out (
        .clk_in(clk_in),
        .reset(reset),
        .bits_upper(slice_bits[0]),
        .bits_lower(slice_bits[1]),
        .shift_phase(shift_phase),
        .latch_req(latch_req),
        .oe_in(oe_int),
        .r1(r1),
        .g1(g1),
        .b1(b1),
        .r2(r2),
        .g2(g2),
        .b2(b2),
        .clk_pixel(clk_pixel),
        .row_latch(row_latch),
        .output_enable(output_enable),
        .row_address_in(scan_row),
        .row_address(row_address)
    );

endmodule

`default_nettype wire

//--- verif/led_matrix_checks.sv
`timescale 1ns/1ps
`default_nettype none

module led_matrix_checks import panel_pkg::*; #(
    parameter int PIXEL_WIDTH = 8,
    parameter int PIXEL_HALFHEIGHT = 4,
    parameter int BRIGHTNESS_LEVELS = 4,
    parameter int BASE_TICKS = 4
) (
    input  logic   clk_in,
    input  logic   reset,
    input  logic   wb_ack,
    input  logic   r1,
    input  logic   g1,
    input  logic   b1,
    input  logic   r2,
    input  logic   g2,
    input  logic   b2,
    input  logic   clk_pixel,
    input  logic   row_latch,
    input  logic   output_enable,
    input  row_t   row_address,
    input  logic   image_ready,
    input  pixel_t image_upper [PIXEL_WIDTH*PIXEL_HALFHEIGHT],
    input  pixel_t image_lower [PIXEL_WIDTH*PIXEL_HALFHEIGHT],
    output int     checked_latches,
    output logic   check_error
);

    localparam int W = PIXEL_WIDTH;
    localparam int BL = BRIGHTNESS_LEVELS;

    // scan position as expected from the pins
    int   row_m;
    int   plane_m;
    int   edge_k;
    int   oe_len;
    int   latched_plane;
    int   arm_count;
    int   post_reset;
    int   latch_total;
    logic prev_clk;
    logic prev_oe;
    logic colour_on;
    logic error_flag = 1'b0;

    assign check_error = error_flag;
    assign checked_latches = latch_total;

    // {red, green, blue} bit of one plane, red field on top
    function automatic rgb_bits_t plane_bits(input pixel_t p, input int plane);
        return {p[2*BL + plane], p[BL + plane], p[plane]};
    endfunction

    // all panel strobes, colours and the ack quiet
    task automatic check_idle_pins(input string when_txt);
        assert ({clk_pixel, row_latch, output_enable, wb_ack, r1, g1, b1, r2, g2, b2} == '0
                && row_address == '0) else begin
            $display("[FAIL] pins %s expected 000/0 got %h/%h", when_txt,
                {clk_pixel, row_latch, output_enable, wb_ack, r1, g1, b1, r2, g2, b2},
                row_address);
            error_flag = 1'b1;
        end
    endtask

    // sampled mid-cycle, all pins settled
    always @(negedge clk_in) begin
        int idx;
        if (reset) begin
            check_idle_pins("in reset");
            row_m = 0;
            plane_m = BL - 1;
            edge_k = 0;
            oe_len = 0;
            latched_plane = BL - 1;
            arm_count = 0;
            colour_on = 1'b0;
            latch_total = 0;
            post_reset = 1;
        end else begin
            if (post_reset > 0) begin
                check_idle_pins("after reset");
                post_reset--;
            end
            assert (!(row_latch && output_enable)) else begin
                $display("[FAIL] row_latch with output_enable expected 0 got %h", row_latch);
                error_flag = 1'b1;
            end
            // k-th rising clk_pixel carries column W-1-k
            if (clk_pixel && !prev_clk) begin
                if (colour_on && edge_k < W) begin
                    idx = row_m * W + (W - 1 - edge_k);
                    assert ({r1, g1, b1} == plane_bits(image_upper[idx], plane_m)) else begin
                        $display("[FAIL] {r1,g1,b1} row %0d plane %0d col %0d expected %h got %h",
                            row_m, plane_m, W - 1 - edge_k,
                            plane_bits(image_upper[idx], plane_m), {r1, g1, b1});
                        error_flag = 1'b1;
                    end
                    assert ({r2, g2, b2} == plane_bits(image_lower[idx], plane_m)) else begin
                        $display("[FAIL] {r2,g2,b2} row %0d plane %0d col %0d expected %h got %h",
                            row_m, plane_m, W - 1 - edge_k,
                            plane_bits(image_lower[idx], plane_m), {r2, g2, b2});
                        error_flag = 1'b1;
                    end
                end
                edge_k++;
            end
            if (row_latch) begin
                assert (edge_k == W) else begin
                    $display("[FAIL] clk_pixel edges per latch expected %h got %h", W, edge_k);
                    error_flag = 1'b1;
                end
                assert (row_address == row_t'(row_m)) else begin
                    $display("[FAIL] row_address expected %h got %h", row_m, row_address);
                    error_flag = 1'b1;
                end
                if (colour_on) begin
                    latch_total++;
                end
                // colour checks start with a shift that began after the load
                if (image_ready) begin
                    arm_count++;
                end
                colour_on = (arm_count >= 2);
                latched_plane = plane_m;
                // msb plane first, row steps after the lsb plane
                if (plane_m == 0) begin
                    plane_m = BL - 1;
                    row_m = (row_m == PIXEL_HALFHEIGHT - 1) ? 0 : row_m + 1;
                end else begin
                    plane_m--;
                end
                edge_k = 0;
            end
            // on-time weighted by the plane just latched
            if (output_enable) begin
                oe_len++;
            end else if (prev_oe) begin
                assert (oe_len == (BASE_TICKS << latched_plane)) else begin
                    $display("[FAIL] output_enable width plane %0d expected %h got %h",
                        latched_plane, BASE_TICKS << latched_plane, oe_len);
                    error_flag = 1'b1;
                end
                oe_len = 0;
            end
        end
        prev_clk = clk_pixel;
        prev_oe = output_enable;
    end

endmodule

`default_nettype wire

//--- verif/led_matrix_tb.sv
`timescale 1ns/1ps
`default_nettype none

module led_matrix_tb import panel_pkg::*, wb_pkg::*; ();

    // small panel so a full frame runs quickly
    localparam int W = 8;
    localparam int H = 4;
    localparam int BL = 4;
    localparam int BT = 4;
    localparam int CW = $clog2(W);
    localparam int RW = $clog2(H);
    localparam int PIXELS = W * H;
    localparam int PIX_MASK = (1 << (3 * BL)) - 1;
    // per plane at most the on-time plus one shift
    localparam int FRAME_CYCLES = H * (BL * (2 * W + 6) + BT * ((1 << BL) - 1));
    // writes and reads of both halves, three cycles each
    localparam int LOAD_CYCLES = 2 * 2 * PIXELS * 3;
    localparam int WATCHDOG_NS = (LOAD_CYCLES + 2 * FRAME_CYCLES) * 3 / 2 * 40;

    logic     clk_in = 1'b0;
    logic     reset;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic     wb_ack;
    logic     r1;
    logic     g1;
    logic     b1;
    logic     r2;
    logic     g2;
    logic     b2;
    logic     clk_pixel;
    logic     row_latch;
    logic     output_enable;
    row_t     row_address;
    logic     image_ready;
    int       checked_latches;
    logic     check_error;

    // model image, index is {row, column}
    pixel_t image_upper [PIXELS];
    pixel_t image_lower [PIXELS];

    always #20 clk_in = ~clk_in;

    led_matrix_top #(
        .PIXEL_WIDTH(W),
        .PIXEL_HALFHEIGHT(H),
        .BRIGHTNESS_LEVELS(BL),
        .BASE_TICKS(BT)
    ) i_led_matrix_top (
        .clk_in(clk_in),
        .reset(reset),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack),
        .r1(r1),
        .g1(g1),
        .b1(b1),
        .r2(r2),
        .g2(g2),
        .b2(b2),
        .clk_pixel(clk_pixel),
        .row_latch(row_latch),
        .output_enable(output_enable),
        .row_address(row_address)
    );

    led_matrix_checks #(
        .PIXEL_WIDTH(W),
        .PIXEL_HALFHEIGHT(H),
        .BRIGHTNESS_LEVELS(BL),
        .BASE_TICKS(BT)
    ) i_led_matrix_checks (
        .clk_in(clk_in),
        .reset(reset),
        .wb_ack(wb_ack),
        .r1(r1),
        .g1(g1),
        .b1(b1),
        .r2(r2),
        .g2(g2),
        .b2(b2),
        .clk_pixel(clk_pixel),
        .row_latch(row_latch),
        .output_enable(output_enable),
        .row_address(row_address),
        .image_ready(image_ready),
        .image_upper(image_upper),
        .image_lower(image_lower),
        .checked_latches(checked_latches),
        .check_error(check_error)
    );

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    // half on top of {row, column}, W is a power of two
    function automatic wb_addr_t pixel_addr(input int half, input int idx);
        return wb_addr_t'((half << (CW + RW)) | idx);
    endfunction

    function automatic pixel_t model_pixel(input int half, input int idx);
        return (half == 1) ? image_lower[idx] : image_upper[idx];
    endfunction

    // one classic cycle, called 2 ns after a rising edge
    task automatic wb_transfer(input logic we, input wb_addr_t addr, input wb_data_t wdata,
                               output wb_data_t rdata);
        int waited;
        waited = 0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = addr;
        wb_dat_w = wdata;
        do begin
            @(posedge clk_in);
            #1;
            waited++;
        end while (!wb_ack && waited < 8);
        assert (wb_ack && waited == 1) else begin
            $display("[FAIL] wb_ack adr %h expected 1 after 1 cycle got %h after %0d",
                addr, wb_ack, waited);
            abort_run();
        end
        rdata = wb_dat_r;
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        @(posedge clk_in);
        #1;
        // single-cycle ack
        assert (!wb_ack) else begin
            $display("[FAIL] wb_ack adr %h expected 0 got %h", addr, wb_ack);
            abort_run();
        end
        #1;
    endtask

    always @(posedge check_error) begin
        abort_run();
    end

    initial begin
        wb_data_t rdata;
        reset = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        image_ready = 1'b0;
        void'($urandom(25928));
        for (int i = 0; i < PIXELS; i++) begin
            image_upper[i] = pixel_t'($urandom() & PIX_MASK);
            image_lower[i] = pixel_t'($urandom() & PIX_MASK);
        end
        repeat (3) @(posedge clk_in);
        #2;
        reset = 1'b0;
        // load while the scan is already running
        for (int h = 0; h < 2; h++) begin
            for (int i = 0; i < PIXELS; i++) begin
                wb_transfer(1'b1, pixel_addr(h, i), wb_data_t'(model_pixel(h, i)), rdata);
            end
        end
        for (int h = 0; h < 2; h++) begin
            for (int i = 0; i < PIXELS; i++) begin
                wb_transfer(1'b0, pixel_addr(h, i), '0, rdata);
                assert ((rdata & wb_data_t'(PIX_MASK)) == wb_data_t'(model_pixel(h, i))) else begin
                    $display("[FAIL] wb_dat_r adr %h expected %h got %h",
                        pixel_addr(h, i), model_pixel(h, i), rdata);
                    abort_run();
                end
            end
        end
        image_ready = 1'b1;
        // two full frames of checked planes
        while (checked_latches < 2 * H * BL) begin
            @(posedge clk_in);
        end
        if (check_error) begin
            abort_run();
        end else begin
            $display("Test passed");
            $finish;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the scan did not finish two checked frames in %0d ns", WATCHDOG_NS);
        abort_run();
    end

endmodule

`default_nettype wire

//--- build.f
source/panel_pkg.sv
source/wb_pkg.sv
source/scan_rd_if.sv
source/wb_frame_store.sv
source/matrix_scan.sv
source/brightness_timer.sv
source/half_panel_slice.sv
source/hub75_out.sv
source/led_matrix_top.sv
verif/led_matrix_checks.sv
verif/led_matrix_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := led_matrix_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Test passed
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run check clean

all: check

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

$(LOG): $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

check: $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
